/* src/icache_cfg_pkg.sv */
`default_nettype none

package icache_cfg_pkg;

  // basic widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // 64-byte lines, 128 of them, direct mapped
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 7;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // word position inside a line
  localparam int WORD_SEL_W     = 4;
  localparam int WORDS_PER_LINE = 1 << WORD_SEL_W;
  localparam int NUM_LINES      = 1 << INDEX_W;

  // byte bits below the word select
  localparam int BYTE_OFF_W = OFFSET_W - WORD_SEL_W;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

  // fetch address split into cache fields, tag in the top bits
  typedef struct packed {
    tag_t                  tag;
    index_t                index;
    word_sel_t             word_sel;
    logic [BYTE_OFF_W-1:0] byte_off;
  } fetch_addr_t;

endpackage

`default_nettype wire

/* src/icache_bus_pkg.sv */
`default_nettype none

package icache_bus_pkg;

  import icache_cfg_pkg::*;

  // beats minus one, 0 for a single word
  typedef logic [7:0] burst_len_t;

  // read request towards memory, valid is a level
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    burst_len_t len;
  } mem_req_t;

  // one refill beat into the data store
  typedef struct packed {
    logic      en;
    index_t    index;
    word_sel_t word_sel;
    word_t     data;
  } data_wr_t;

  // tag update at the end of a refill
  typedef struct packed {
    logic   en;
    index_t index;
    tag_t   tag;
  } tag_wr_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED
  } icache_state_e;

endpackage

`default_nettype wire

/* src/icache_tag_store.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_tag_store
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  // registered lookup address from the controller
  input  fetch_addr_t lookup_i,
  // written once per refill, after the last beat
  input  tag_wr_t     tag_wr_i,
  output logic        hit_o
);

  // one valid bit per line, cleared on reset
  logic [NUM_LINES-1:0] valid_q;

  // stored tags
  tag_t tag_q [NUM_LINES];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_wr_i.en) begin
      // line becomes usable with the tag write
      valid_q[tag_wr_i.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wr_i.en) begin
      tag_q[tag_wr_i.index] <= tag_wr_i.tag;
    end
  end

  // direct mapped, so a single compare per lookup
  assign hit_o = valid_q[lookup_i.index] && (tag_q[lookup_i.index] == lookup_i.tag);

endmodule

`default_nettype wire

/* src/icache_data_store.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_data_store
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  wire         clk,
  // index and word select of the current lookup
  input  fetch_addr_t lookup_i,
  // one word per refill beat
  input  data_wr_t    data_wr_i,
  output word_t       rdata_o
);

  // 128 lines x 16 words
  word_t mem_q [NUM_LINES][WORDS_PER_LINE];

  // refill write, the beat counter picks the word
  always_ff @(posedge clk) begin
    if (data_wr_i.en) begin
      mem_q[data_wr_i.index][data_wr_i.word_sel] <= data_wr_i.data;
    end
  end

  // combinational read
  // hit data is ready in the same cycle as the tag compare
  assign rdata_o = mem_q[lookup_i.index][lookup_i.word_sel];

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
#(
  parameter addr_t UNCACHED_LO = 32'h1000_0000,
  parameter addr_t UNCACHED_HI = 32'h2000_0000
) (
  input  wire         clk,
  input  wire         rst,
  // requester side
  input  addr_t       req_addr_i,
  input  wire         req_valid_i,
  // store side
  input  wire         hit_i,
  input  word_t       store_rdata_i,
  output fetch_addr_t lookup_o,
  output tag_wr_t     tag_wr_o,
  output data_wr_t    data_wr_o,
  // memory side
  output mem_req_t    mem_req_o,
  input  word_t       mem_rdata_i,
  input  wire         mem_rvalid_i,
  // response
  output word_t       rdata_o,
  output logic        rdata_valid_o
);

  icache_state_e state;

  // captured request feeding both stores
  fetch_addr_t lookup_q;

  // refill word position
  word_sel_t beat_cnt;

  mem_req_t mem_req_q;

  // uncached word handed out for one cycle in IDLE
  word_t unc_data_q;
  logic  unc_valid_q;

  logic uncached;
  logic lookup_hit;
  logic beat;
  logic last_beat;

  // window check on the captured address
  assign uncached = (addr_t'(lookup_q) >= UNCACHED_LO) && (addr_t'(lookup_q) < UNCACHED_HI);

  // a window edge inside a line leaves window words in a refilled line
  assign lookup_hit = hit_i && !uncached;

  // a strobe only counts while the request is up
  assign beat      = mem_req_q.valid && mem_rvalid_i;
  assign last_beat = (beat_cnt == word_sel_t'(WORDS_PER_LINE - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= IDLE;
      mem_req_q.valid <= 1'b0;
      unc_valid_q     <= 1'b0;
      beat_cnt        <= '0;
    end else begin
      // single-cycle pulse
      unc_valid_q <= 1'b0;
      case (state)
        IDLE: begin
          if (req_valid_i) begin
            lookup_q <= fetch_addr_t'(req_addr_i);
            state    <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (uncached) begin
            // single word at the word-aligned address
            mem_req_q.valid <= 1'b1;
            mem_req_q.addr  <= {lookup_q.tag, lookup_q.index, lookup_q.word_sel,
                                {BYTE_OFF_W{1'b0}}};
            mem_req_q.len   <= '0;
            state           <= UNCACHED;
          end else if (lookup_hit) begin
            // stream the next request straight in
            if (req_valid_i) begin
              lookup_q <= fetch_addr_t'(req_addr_i);
            end else begin
              state <= IDLE;
            end
          end else begin
            // burst the whole missed line from its base
            mem_req_q.valid <= 1'b1;
            mem_req_q.addr  <= {lookup_q.tag, lookup_q.index, {OFFSET_W{1'b0}}};
            mem_req_q.len   <= burst_len_t'(WORDS_PER_LINE - 1);
            beat_cnt        <= '0;
            state           <= REFILL;
          end
        end
        REFILL: begin
          if (beat) begin
            if (last_beat) begin
              // held address is looked up again from IDLE
              mem_req_q.valid <= 1'b0;
              state           <= IDLE;
            end else begin
              beat_cnt <= beat_cnt + word_sel_t'(1);
            end
          end
        end
        UNCACHED: begin
          if (beat) begin
            mem_req_q.valid <= 1'b0;
            unc_data_q      <= mem_rdata_i;
            unc_valid_q     <= 1'b1;
            state           <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // refill writes go straight from the memory beat into the stores
  always_comb begin
    data_wr_o.en       = (state == REFILL) && beat;
    data_wr_o.index    = lookup_q.index;
    data_wr_o.word_sel = beat_cnt;
    data_wr_o.data     = mem_rdata_i;
    // tag lands with the 16th word
    tag_wr_o.en        = data_wr_o.en && last_beat;
    tag_wr_o.index     = lookup_q.index;
    tag_wr_o.tag       = lookup_q.tag;
  end

  assign lookup_o  = lookup_q;
  assign mem_req_o = mem_req_q;

  // stored word on a hit and the uncached register otherwise
  assign rdata_o       = (state == LOOKUP) ? store_rdata_i : unc_data_q;
  assign rdata_valid_o = ((state == LOOKUP) && lookup_hit) || unc_valid_q;

endmodule

`default_nettype wire

/* src/icache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_top
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
#(
  // uncached window, LO inclusive and HI exclusive
  parameter addr_t UNCACHED_LO = 32'h1000_0000,
  parameter addr_t UNCACHED_HI = 32'h2000_0000
) (
  input  wire      clk,
  input  wire      rst,
  // fetch request, held until rdata_valid_o
  input  addr_t    req_addr_i,
  input  wire      req_valid_i,
  output word_t    rdata_o,
  output logic     rdata_valid_o,
  // memory read port
  output mem_req_t mem_req_o,
  input  word_t    mem_rdata_i,
  input  wire      mem_rvalid_i
);

  fetch_addr_t lookup;
  tag_wr_t     tag_wr;
  data_wr_t    data_wr;
  logic        hit;
  word_t       store_rdata;

  icache_ctrl #(
    .UNCACHED_LO (UNCACHED_LO),
    .UNCACHED_HI (UNCACHED_HI)
  ) icache_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .req_addr_i    (req_addr_i),
    .req_valid_i   (req_valid_i),
    .hit_i         (hit),
    .store_rdata_i (store_rdata),
    .lookup_o      (lookup),
    .tag_wr_o      (tag_wr),
    .data_wr_o     (data_wr),
    .mem_req_o     (mem_req_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o)
  );

  // valid bits and tags
  icache_tag_store icache_tag_store_inst (
    .clk      (clk),
    .rst      (rst),
    .lookup_i (lookup),
    .tag_wr_i (tag_wr),
    .hit_o    (hit)
  );

  // line data, internal array
  icache_data_store icache_data_store_inst (
    .clk       (clk),
    .lookup_i  (lookup),
    .data_wr_i (data_wr),
    .rdata_o   (store_rdata)
  );

endmodule

`default_nettype wire

/* verif/tb_icache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_icache
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
();

  localparam addr_t UNC_LO = 32'h1000_0000;
  localparam addr_t UNC_HI = 32'h2000_0000;

  // directed reads: 1 cold, 16 same line, 6 eviction, 4 uncached
  localparam int NUM_DIRECTED = 27;
  localparam int NUM_RANDOM   = 400;
  localparam int NUM_REQ      = NUM_DIRECTED + NUM_RANDOM;
  // 16 beats with up to 3 gap cycles each, plus lookup overhead
  localparam int TIMEOUT_CYCLES = NUM_REQ * 80;

  typedef enum {PRED_HIT, PRED_MISS, PRED_UNCACHED} pred_e;

  logic     clk;
  logic     rst;
  addr_t    req_addr;
  logic     req_valid;
  word_t    rdata;
  logic     rdata_valid;
  mem_req_t mem_req;
  word_t    mem_rdata;
  logic     mem_rvalid;

  int seed;
  int cycles;
  int bursts;

  // memory model state
  addr_t burst_base;
  int    burst_len;
  int    gap;

  // reference model, valid bit and tag per line
  logic model_valid [NUM_LINES];
  tag_t model_tag [NUM_LINES];

  // random stream, built before the run
  addr_t stream_addr [NUM_RANDOM];
  logic  stream_idle [NUM_RANDOM];

  icache_top #(
    .UNCACHED_LO (UNC_LO),
    .UNCACHED_HI (UNC_HI)
  ) icache_top_inst (
    .clk           (clk),
    .rst           (rst),
    .req_addr_i    (req_addr),
    .req_valid_i   (req_valid),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid),
    .mem_req_o     (mem_req),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the cache stopped answering", cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  // memory contents, a fixed function of the word address
  function automatic word_t mem_word(input addr_t addr);
    word_t x;
    int    r;
    x = addr ^ 32'hA5C3_0F1E;
    r = int'(addr[6:2]);
    mem_word = (x << r) | (x >> ((32 - r) % 32));
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error: %s expected word %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      $display("Error: %s expected request valid %b addr %h len %0d actual valid %b addr %h len %0d",
               name, exp.valid, exp.addr, exp.len, act.valid, act.addr, act.len);
      abort_run();
    end
  endtask

  // sampled one cycle after capture
  task automatic check_hit(input string name);
    if (rdata_valid !== 1'b1 || mem_req.valid !== 1'b0) begin
      $display("Error: %s expected rdata_valid 1 and request valid 0 actual %b and %b",
               name, rdata_valid, mem_req.valid);
      abort_run();
    end
  endtask

  // memory model, one burst at a time, random beat gaps
  initial begin
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    bursts     = 0;
    forever begin
      @(negedge clk);
      if (!rst && mem_req.valid) begin
        burst_base = mem_req.addr;
        burst_len  = int'(mem_req.len);
        bursts     = bursts + 1;
        for (int k = 0; k <= burst_len; k++) begin
          gap = $random(seed) & 3;
          repeat (gap) @(negedge clk);
          // beat k carries the word at base plus 4k
          mem_rdata  = mem_word(burst_base + addr_t'(4 * k));
          mem_rvalid = 1'b1;
          @(negedge clk);
          mem_rvalid = 1'b0;
        end
      end
    end
  end

  // called on a falling edge, returns on the falling edge of the response
  task automatic run_request(input string name, input addr_t addr);
    fetch_addr_t fa;
    addr_t       word_addr;
    mem_req_t    exp_req;
    pred_e       pred;
    int          bursts_before;
    fa        = fetch_addr_t'(addr);
    word_addr = {addr[ADDR_W-1:2], 2'b00};
    if (addr >= UNC_LO && addr < UNC_HI) begin
      pred = PRED_UNCACHED;
    end else if (model_valid[fa.index] && model_tag[fa.index] == fa.tag) begin
      pred = PRED_HIT;
    end else begin
      pred = PRED_MISS;
    end
    bursts_before = bursts;
    req_addr  = addr;
    req_valid = 1'b1;
    // captured at the next rising edge
    @(negedge clk);
    if (pred == PRED_HIT) begin
      check_hit(name);
    end else begin
      @(negedge clk);
      exp_req.valid = 1'b1;
      if (pred == PRED_UNCACHED) begin
        exp_req.addr = word_addr;
        exp_req.len  = '0;
      end else begin
        exp_req.addr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        exp_req.len  = burst_len_t'(WORDS_PER_LINE - 1);
      end
      check_req(name, exp_req, mem_req);
      while (!rdata_valid) begin
        @(negedge clk);
      end
      if (bursts != bursts_before + 1) begin
        $display("%s: memory saw %0d requests for one read", name, bursts - bursts_before);
        abort_run();
      end
      if (pred == PRED_MISS) begin
        model_valid[fa.index] = 1'b1;
        model_tag[fa.index]   = fa.tag;
      end
    end
    check_word(name, mem_word(word_addr), rdata);
  endtask

  // small mix of lines, several sharing an index, plus the uncached window
  function automatic addr_t pick_base(input int sel);
    case (sel)
      0:       pick_base = 32'h0000_0000;
      1:       pick_base = 32'h0000_0040;
      2:       pick_base = 32'h0000_2000;
      3:       pick_base = 32'h8000_0040;
      4:       pick_base = 32'h2000_0000;
      5:       pick_base = 32'h0FFF_FFC0;
      6:       pick_base = 32'h1000_0000;
      default: pick_base = 32'h1FFF_FFC0;
    endcase
  endfunction

  initial begin
    rst       = 1'b1;
    req_addr  = '0;
    req_valid = 1'b0;
    cycles    = 0;
    seed      = 32'hf450;
    for (int i = 0; i < NUM_LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      stream_addr[i] = pick_base($random(seed) & 7) | addr_t'($random(seed) & 63);
      // mostly back to back, sometimes an idle cycle
      stream_idle[i] = (($random(seed) & 3) == 0);
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    run_request("cold_read", 32'h0000_1248);
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      run_request("same_line", 32'h0000_1240 + addr_t'(4 * w));
    end

    // same index 0x42, different tags
    run_request("evict", 32'h0000_3080);
    run_request("evict", 32'h0000_3084);
    run_request("evict", 32'h0004_3080);
    run_request("evict", 32'h0000_3080);
    run_request("evict", 32'h0004_30bc);
    run_request("evict", 32'h0004_3088);

    run_request("uncached", 32'h1000_0000);
    run_request("uncached", 32'h1FFF_FFFC);
    run_request("uncached", 32'h1234_5679);
    run_request("uncached", 32'h1000_0000);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (stream_idle[i]) begin
        req_valid = 1'b0;
        @(negedge clk);
      end
      run_request($sformatf("random_%0d", i), stream_addr[i]);
    end
    req_valid = 1'b0;
    @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
src/icache_cfg_pkg.sv
src/icache_bus_pkg.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_ctrl.sv
src/icache_top.sv
verif/tb_icache.sv

/* Makefile */
SIM       = verilator
TOP       = tb_icache
FILELIST  = tb.f
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
OBJDIR    = obj_dir
PASS_MSG  = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# exit status comes from the search for the pass message
run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
